// File: lcd_serial.f
source/lcd_pkg.sv
source/key_debounce.sv
source/tile_pattern.sv
source/lcd_sequencer.sv
source/serial_shifter.sv
source/lcd_serial.sv
sim/lcd_serial_assertions.sv
sim/lcd_serial_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# builds the testbench with Verilator, runs it and looks for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log

verilator --binary --timing --assert -Wno-fatal --top-module lcd_serial_tb \
	-f lcd_serial.f -o lcd_serial_sim > build.log 2>&1 \
	&& ./obj_dir/lcd_serial_sim > sim.log 2>&1 \
	|| { echo "build or simulation error, see build.log and sim.log"; exit 1; }

grep -q "SIMULATION PASSED" sim.log && echo "pass" \
	|| { echo "fail, see sim.log"; exit 1; }

// File: sim/lcd_serial_assertions.sv
/* protocol checks on the serial pins, sampled on clk27; bound into lcd_serial */

module lcd_serial_assertions (
	input logic clk27,
	input logic rst_n,
	input logic serlcd_sel,
	input logic serlcd_cmd,
	input logic serlcd_clk
);
	timeunit 1ns;
	timeprecision 1ps;

	// clock edges only inside a selected transfer
	clk_needs_sel: assert property (@(posedge clk27) disable iff (!rst_n)
		$rose(serlcd_clk) |-> !serlcd_sel)
		else $error("serial clock rose with select high");

	// bus parked while in reset
	idle_in_reset: assert property (@(posedge clk27) !rst_n |-> (serlcd_sel && !serlcd_clk))
		else $error("select or serial clock active during reset");

	// command/data flag settles before the clock goes high
	cmd_stable: assert property (@(posedge clk27) disable iff (!rst_n)
		serlcd_clk |-> $stable(serlcd_cmd))
		else $error("command/data line changed with serial clock high");

endmodule

bind lcd_serial lcd_serial_assertions lcd_serial_assertions0 (.clk27(clk27), .rst_n(rst_n),
	.serlcd_sel(serlcd_sel), .serlcd_cmd(serlcd_cmd), .serlcd_clk(serlcd_clk));

// File: sim/lcd_serial_tb.sv
/* decodes the serial pins back into bytes and checks them against the frame layout;
   runs about three full frames, so expect a few million clock cycles */

module lcd_serial_tb;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int CLK_PERIOD  = 8;
	localparam int PIXEL_BYTES = lcd_pkg::SCREEN_WIDTH * lcd_pkg::SCREEN_HEIGHT * 2;
	// window bytes, ramwr, then the pixels
	localparam int FRAME_BYTES = 11 + PIXEL_BYTES;
	localparam int HOLD_GAP    = 20000;
	localparam real WATCHDOG_NS = 3.5 * 64813.0 * 17.0 * CLK_PERIOD
		+ (3 + lcd_pkg::LCD_RST_CYCLES + lcd_pkg::LCD_WAIT_CYCLES
		+ lcd_pkg::INIT_LEN * 17) * CLK_PERIOD;

	logic       clk27;
	logic       rst_n;
	logic [1:0] key;
	logic       serlcd_ena;
	logic       serlcd_sel;
	logic       serlcd_cmd;
	logic       serlcd_clk;
	logic       serlcd_out;

	logic [31:0] lfsr;
	logic [7:0]  shift_in;
	int          nbits = 0;
	// flag in bit 8, byte below
	logic [8:0]  rx_q[$];
	int          rx_idx = 0;
	int          test_errors[1:6] = '{default: 0};
	int          failed = 0;
	int          total;

	lcd_serial dut0 (.clk27(clk27), .rst_n(rst_n), .key(key), .serlcd_ena(serlcd_ena),
		.serlcd_sel(serlcd_sel), .serlcd_cmd(serlcd_cmd), .serlcd_clk(serlcd_clk),
		.serlcd_out(serlcd_out));

	initial begin
		clk27 = 1'b0;
		forever #(CLK_PERIOD / 2) clk27 = ~clk27;
	end

	// --------------------------------------------------
	// random source and helpers
	// --------------------------------------------------
	// galois form, taps 32 31 29 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		lfsr_next = s[0] ? ((s >> 1) ^ 32'hd000_0001) : (s >> 1);
	endfunction

	task automatic draw_bits(input int n, output int val);
		val = 0;
		for (int i = 0; i < n; i++) begin
			val = (val << 1) | int'(lfsr[0]);
			lfsr = lfsr_next(lfsr);
		end
	endtask

	task automatic set_key(input int i, input logic v);
		@(posedge clk27);
		#1 key[i] = v;
	endtask

	task automatic wait_bytes(input int n);
		while (rx_idx < n)
			@(posedge clk27);
		#1;
	endtask

	task automatic report(input int num, input string name);
		if (test_errors[num] == 0) begin
			$display("test %0d %s: ok", num, name);
		end else begin
			failed++;
			$display("test %0d %s: failed with %0d errors", num, name, test_errors[num]);
		end
	endtask

	// --------------------------------------------------
	// reference stream
	// --------------------------------------------------
	// expected {is_data, byte} at stream position idx
	function automatic logic [8:0] expected_byte(input int idx, input logic tp);
		int k;
		int p;
		int x;
		int y;
		logic [15:0] x1;
		logic [15:0] y1;
		logic [15:0] color;
		x1 = 16'(lcd_pkg::SCREEN_HOFFS + lcd_pkg::SCREEN_WIDTH - 1);
		y1 = 16'(lcd_pkg::SCREEN_VOFFS + lcd_pkg::SCREEN_HEIGHT - 1);
		if (idx < lcd_pkg::INIT_LEN)
			return {lcd_pkg::INIT_IS_DATA[idx], lcd_pkg::INIT_BYTES[idx]};
		k = (idx - lcd_pkg::INIT_LEN) % FRAME_BYTES;
		case (k)
			0:  return {1'b0, lcd_pkg::CMD_CASET};
			1:  return {1'b1, 8'(lcd_pkg::SCREEN_HOFFS >> 8)};
			2:  return {1'b1, 8'(lcd_pkg::SCREEN_HOFFS)};
			3:  return {1'b1, x1[15:8]};
			4:  return {1'b1, x1[7:0]};
			5:  return {1'b0, lcd_pkg::CMD_RASET};
			6:  return {1'b1, 8'(lcd_pkg::SCREEN_VOFFS >> 8)};
			7:  return {1'b1, 8'(lcd_pkg::SCREEN_VOFFS)};
			8:  return {1'b1, y1[15:8]};
			9:  return {1'b1, y1[7:0]};
			10: return {1'b0, lcd_pkg::CMD_RAMWR};
			default: ;
		endcase
		// raster order, two bytes per pixel
		p = (k - 11) / 2;
		x = p % lcd_pkg::SCREEN_WIDTH;
		y = p / lcd_pkg::SCREEN_WIDTH;
		if (!tp)
			color = lcd_pkg::COLOR_SOLID;
		else if ((x / lcd_pkg::TILE_WIDTH + y / lcd_pkg::TILE_HEIGHT) % 2 == 1)
			color = lcd_pkg::COLOR_TILE_ODD;
		else
			color = lcd_pkg::COLOR_TILE_EVEN;
		return ((k - 11) % 2 == 0) ? {1'b1, color[15:8]} : {1'b1, color[7:0]};
	endfunction

	// which test a stream position belongs to
	function automatic int byte_test(input int idx);
		if (idx < lcd_pkg::INIT_LEN)
			return 2;
		if (idx >= lcd_pkg::INIT_LEN + 3 * FRAME_BYTES)
			return 6;
		if ((idx - lcd_pkg::INIT_LEN) % FRAME_BYTES < 11)
			return 3;
		if (idx < lcd_pkg::INIT_LEN + FRAME_BYTES)
			return 4;
		if (idx < lcd_pkg::INIT_LEN + 2 * FRAME_BYTES)
			return 5;
		// third frame pixels, finished under hold
		return 6;
	endfunction

	// --------------------------------------------------
	// serial decoder and compare
	// --------------------------------------------------
	always @(posedge serlcd_clk) begin
		if (!serlcd_sel) begin
			if (!serlcd_ena) begin
				test_errors[1]++;
				$display("serial clock running while the panel is still in reset");
			end
			shift_in = {shift_in[6:0], serlcd_out};
			nbits++;
			if (nbits == 8) begin
				rx_q.push_back({serlcd_cmd, shift_in});
				nbits = 0;
			end
		end
	end

	always @(posedge clk27) begin
		logic [8:0] got;
		logic [8:0] want;
		int         num;
		while (rx_q.size() > 0) begin
			got  = rx_q.pop_front();
			// first frame solid; the key press lands before the second one
			want = expected_byte(rx_idx, rx_idx >= lcd_pkg::INIT_LEN + FRAME_BYTES);
			num  = byte_test(rx_idx);
			if (got[7:0] !== want[7:0]) begin
				test_errors[num]++;
				$display("mismatch serlcd_out at byte %0d: got %h, expected %h",
					rx_idx, got[7:0], want[7:0]);
			end
			if (got[8] !== want[8]) begin
				test_errors[num]++;
				$display("mismatch serlcd_cmd at byte %0d: got %h, expected %h",
					rx_idx, got[8], want[8]);
			end
			rx_idx++;
		end
	end

	// --------------------------------------------------
	// test sequence
	// --------------------------------------------------
	initial begin
		int delay;
		int length;
		int n;
		lfsr  = 32'hc60;
		key   = 2'b11;
		rst_n = 1'b1;
		#1 rst_n = 1'b0;
		repeat (3) @(posedge clk27);
		if (serlcd_ena !== 1'b0 || serlcd_sel !== 1'b1 || serlcd_clk !== 1'b0) begin
			test_errors[1]++;
			$display("mismatch serlcd_ena/sel/clk in reset: got %h%h%h, expected 010",
				serlcd_ena, serlcd_sel, serlcd_clk);
		end
		#1 rst_n = 1'b1;
		n = 0;
		while (serlcd_ena !== 1'b1) begin
			@(posedge clk27);
			#1 n++;
		end
		if (n < lcd_pkg::LCD_RST_CYCLES) begin
			test_errors[1]++;
			$display("panel reset released too early, after %0d cycles", n);
		end
		if (nbits != 0 || rx_q.size() != 0 || rx_idx != 0) begin
			test_errors[1]++;
			$display("serial bits sent before the panel reset was released");
		end
		report(1, "panel reset");
		wait_bytes(lcd_pkg::INIT_LEN);
		report(2, "init list");

		// key 1 press at a random point of the first frame
		wait_bytes(lcd_pkg::INIT_LEN + 11);
		draw_bits(16, delay);
		draw_bits(11, length);
		repeat (delay) @(posedge clk27);
		set_key(1, 1'b0);
		repeat (2 ** lcd_pkg::DEBOUNCE_BITS + 200 + length) @(posedge clk27);
		set_key(1, 1'b1);
		wait_bytes(lcd_pkg::INIT_LEN + FRAME_BYTES);
		report(4, "solid frame");
		wait_bytes(lcd_pkg::INIT_LEN + 2 * FRAME_BYTES);
		report(5, "test pattern");

		// hold during the third frame
		wait_bytes(lcd_pkg::INIT_LEN + 2 * FRAME_BYTES + 11);
		set_key(0, 1'b0);
		wait_bytes(lcd_pkg::INIT_LEN + 3 * FRAME_BYTES);
		n = rx_idx + rx_q.size();
		repeat (HOLD_GAP) @(posedge clk27);
		#1;
		if (rx_idx + rx_q.size() != n || nbits != 0) begin
			test_errors[6]++;
			$display("bytes arrived while hold was pressed");
		end
		if (serlcd_sel !== 1'b1) begin
			test_errors[6]++;
			$display("mismatch serlcd_sel during hold: got %h, expected 1", serlcd_sel);
		end
		set_key(0, 1'b1);
		wait_bytes(lcd_pkg::INIT_LEN + 3 * FRAME_BYTES + 11);
		report(6, "hold");
		report(3, "window commands");

		total = 0;
		for (int i = 1; i <= 6; i++)
			total += test_errors[i];
		$display("6 tests run, %0d failed, %0d errors", failed, total);
		if (failed == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

	// three and a half frames plus start-up
	initial begin
		#(WATCHDOG_NS);
		$display("watchdog timeout at %0t, %0d bytes received", $time, rx_idx);
		$display("SIMULATION FAILED");
		$finish;
	end

endmodule

// File: source/key_debounce.sv
/* keys are active low and idle high; a level counts only after
   2**DEBOUNCE_BITS stable cycles, so short presses are ignored */

module key_debounce (
	input  logic       clk27,
	input  logic       rst_n,
	input  logic [1:0] key,
	output logic       hold,
	output logic       show_tp
);

	// two-flop synchronizer stages
	logic [1:0] sync_a;
	logic [1:0] sync_b;
	// accepted (debounced) key levels, still active low
	logic [1:0] level;
	logic [1:0][lcd_pkg::DEBOUNCE_BITS-1:0] cnt;
	logic [1:0] accept;

	// new level accepted once the counter has run full
	always_comb begin
		for (int i = 0; i < 2; i++) begin
			accept[i] = (sync_b[i] != level[i]) && (&cnt[i]);
		end
	end

	always_ff @(posedge clk27 or negedge rst_n) begin
		if (!rst_n) begin
			sync_a  <= 2'b11;
			sync_b  <= 2'b11;
			level   <= 2'b11;
			cnt     <= '0;
			show_tp <= 1'b0;
		end else begin
			sync_a <= key;
			sync_b <= sync_a;
			for (int i = 0; i < 2; i++) begin
				// any return to the old level restarts the count
				if (sync_b[i] == level[i])
					cnt[i] <= '0;
				else
					cnt[i] <= cnt[i] + 1'b1;
				if (accept[i])
					level[i] <= sync_b[i];
			end
			// toggle on an accepted press of key 1
			if (accept[1] && !sync_b[1])
				show_tp <= ~show_tp;
		end
	end

	// key 0 held down
	assign hold = ~level[0];

endmodule

// File: source/lcd_pkg.sv
/* shared constants and types for the ST7789 240x135 serial LCD design.
   power-up delays are shortened to a fixed wait and are not datasheet timing */

package lcd_pkg;

	// --------------------------------------------------
	// screen and tile geometry
	// --------------------------------------------------
	localparam int SCREEN_WIDTH  = 240;
	localparam int SCREEN_HEIGHT = 135;
	// visible window inside the 240x320 controller ram
	localparam int SCREEN_HOFFS  = 40;
	localparam int SCREEN_VOFFS  = 53;

	localparam int TILE_WIDTH    = 16;
	localparam int TILE_HEIGHT   = 8;

	typedef logic [7:0]  hpix_t;
	typedef logic [7:0]  vpix_t;
	typedef logic [3:0]  tile_x_t;
	typedef logic [4:0]  tile_y_t;
	// rgb565
	typedef logic [15:0] pixel_t;

	localparam pixel_t COLOR_SOLID     = 16'hf800;
	localparam pixel_t COLOR_TILE_EVEN = 16'hffff;
	localparam pixel_t COLOR_TILE_ODD  = 16'h001f;

	// --------------------------------------------------
	// serial bytes
	// --------------------------------------------------
	typedef logic [7:0] byte_t;

	// sleep out, colmod 16 bit, madctl, invert on, normal mode, display on
	localparam int INIT_LEN = 8;
	localparam logic [0:INIT_LEN-1][7:0] INIT_BYTES =
		{8'h11, 8'h3a, 8'h55, 8'h36, 8'h00, 8'h21, 8'h13, 8'h29};
	// one flag per init byte, 1 for data
	localparam logic [0:INIT_LEN-1] INIT_IS_DATA = 8'b0010_1000;

	localparam byte_t CMD_CASET = 8'h2a;
	localparam byte_t CMD_RASET = 8'h2b;
	localparam byte_t CMD_RAMWR = 8'h2c;

	// --------------------------------------------------
	// timing, in clk27 cycles
	// --------------------------------------------------
	localparam int LCD_RST_CYCLES  = 64;
	localparam int LCD_WAIT_CYCLES = 256;
	localparam int DEBOUNCE_BITS   = 10;

	typedef enum logic [2:0] {RESET, WAIT, INIT, WIN, RAMWR, PIXELS, IDLE} seq_state_t;

endpackage

// File: source/lcd_sequencer.sv
/* frames repeat without pause unless hold is high; show_tp is only
   sampled at frame start, so a frame never mixes the two sources */

module lcd_sequencer (
	input  logic            clk27,
	input  logic            rst_n,
	input  logic            hold,
	input  logic            show_tp,
	input  logic            busy,
	input  lcd_pkg::pixel_t pixel,
	output logic            lcd_rst_n,
	output lcd_pkg::hpix_t  pix_x,
	output lcd_pkg::vpix_t  pix_y,
	output logic            tp_frame,
	output lcd_pkg::byte_t  tx_byte,
	output logic            tx_is_data,
	output logic            tx_strobe
);

	lcd_pkg::seq_state_t state;
	// cycle count in reset/wait, byte index in init/window,
	// bit 0 selects the pixel half in the pixel state
	logic [8:0] cnt;

	// column and row window bytes, in send order
	function automatic lcd_pkg::byte_t win_byte(input logic [3:0] idx);
		logic [15:0] x0;
		logic [15:0] x1;
		logic [15:0] y0;
		logic [15:0] y1;
		x0 = 16'(lcd_pkg::SCREEN_HOFFS);
		x1 = 16'(lcd_pkg::SCREEN_HOFFS + lcd_pkg::SCREEN_WIDTH - 1);
		y0 = 16'(lcd_pkg::SCREEN_VOFFS);
		y1 = 16'(lcd_pkg::SCREEN_VOFFS + lcd_pkg::SCREEN_HEIGHT - 1);
		case (idx)
			4'd0:    win_byte = lcd_pkg::CMD_CASET;
			4'd1:    win_byte = x0[15:8];
			4'd2:    win_byte = x0[7:0];
			4'd3:    win_byte = x1[15:8];
			4'd4:    win_byte = x1[7:0];
			4'd5:    win_byte = lcd_pkg::CMD_RASET;
			4'd6:    win_byte = y0[15:8];
			4'd7:    win_byte = y0[7:0];
			4'd8:    win_byte = y1[15:8];
			default: win_byte = y1[7:0];
		endcase
	endfunction

	// --------------------------------------------------
	// byte selection
	// --------------------------------------------------
	always_comb begin
		tx_byte    = '0;
		tx_is_data = 1'b1;
		case (state)
			lcd_pkg::INIT: begin
				tx_byte    = lcd_pkg::INIT_BYTES[cnt[$clog2(lcd_pkg::INIT_LEN)-1:0]];
				tx_is_data = lcd_pkg::INIT_IS_DATA[cnt[$clog2(lcd_pkg::INIT_LEN)-1:0]];
			end
			lcd_pkg::WIN: begin
				tx_byte    = win_byte(cnt[3:0]);
				tx_is_data = (cnt[3:0] != 4'd0) && (cnt[3:0] != 4'd5);
			end
			lcd_pkg::RAMWR: begin
				tx_byte    = lcd_pkg::CMD_RAMWR;
				tx_is_data = 1'b0;
			end
			// high byte first
			lcd_pkg::PIXELS: tx_byte = cnt[0] ? pixel[7:0] : pixel[15:8];
			default: ;
		endcase
	end

	// a byte goes out as soon as the shifter is free
	assign tx_strobe = (state inside {lcd_pkg::INIT, lcd_pkg::WIN, lcd_pkg::RAMWR,
		lcd_pkg::PIXELS}) && !busy;

	// --------------------------------------------------
	// state machine
	// --------------------------------------------------
	always_ff @(posedge clk27 or negedge rst_n) begin
		if (!rst_n) begin
			state     <= lcd_pkg::RESET;
			cnt       <= '0;
			lcd_rst_n <= 1'b0;
			pix_x     <= '0;
			pix_y     <= '0;
			tp_frame  <= 1'b0;
		end else begin
			case (state)
				lcd_pkg::RESET: begin
					cnt <= cnt + 1'b1;
					if (cnt == 9'(lcd_pkg::LCD_RST_CYCLES - 1)) begin
						cnt       <= '0;
						lcd_rst_n <= 1'b1;
						state     <= lcd_pkg::WAIT;
					end
				end
				lcd_pkg::WAIT: begin
					cnt <= cnt + 1'b1;
					if (cnt == 9'(lcd_pkg::LCD_WAIT_CYCLES - 1)) begin
						cnt   <= '0;
						state <= lcd_pkg::INIT;
					end
				end
				lcd_pkg::INIT: if (tx_strobe) begin
					cnt <= cnt + 1'b1;
					if (cnt == 9'(lcd_pkg::INIT_LEN - 1))
						state <= lcd_pkg::IDLE;
				end
				// frame start, latch the source and rewind the raster
				lcd_pkg::IDLE: if (!hold) begin
					cnt      <= '0;
					pix_x    <= '0;
					pix_y    <= '0;
					tp_frame <= show_tp;
					state    <= lcd_pkg::WIN;
				end
				lcd_pkg::WIN: if (tx_strobe) begin
					cnt <= cnt + 1'b1;
					if (cnt == 9'd9) begin
						cnt   <= '0;
						state <= lcd_pkg::RAMWR;
					end
				end
				lcd_pkg::RAMWR: if (tx_strobe)
					state <= lcd_pkg::PIXELS;
				lcd_pkg::PIXELS: if (tx_strobe) begin
					cnt[0] <= ~cnt[0];
					// move on only after the low byte
					if (cnt[0]) begin
						if (pix_x == lcd_pkg::hpix_t'(lcd_pkg::SCREEN_WIDTH - 1)) begin
							pix_x <= '0;
							if (pix_y == lcd_pkg::vpix_t'(lcd_pkg::SCREEN_HEIGHT - 1))
								state <= lcd_pkg::IDLE;
							else
								pix_y <= pix_y + 1'b1;
						end else begin
							pix_x <= pix_x + 1'b1;
						end
					end
				end
				default: state <= lcd_pkg::RESET;
			endcase
		end
	end

endmodule

// File: source/lcd_serial.sv
/* top for the 240x135 ST7789 panel on 4-wire serial, clocked by clk27.
   key 1 toggles the checkerboard, key 0 pauses between frames */

module lcd_serial (
	// main clock
	input  logic       clk27,
	input  logic       rst_n,

	// active-low keys
	input  logic [1:0] key,

	// lcd pins
	output logic       serlcd_ena,
	output logic       serlcd_sel,
	output logic       serlcd_cmd,
	output logic       serlcd_clk,
	output logic       serlcd_out
);

	logic            hold;
	logic            show_tp;
	logic            tp_frame;
	logic            busy;
	logic            tx_is_data;
	logic            tx_strobe;
	lcd_pkg::byte_t  tx_byte;
	lcd_pkg::hpix_t  pix_x;
	lcd_pkg::vpix_t  pix_y;
	lcd_pkg::pixel_t pixel;

	// --------------------------------------------------
	// keys
	// --------------------------------------------------
	key_debounce key_debounce0 (.clk27(clk27), .rst_n(rst_n), .key(key),
		.hold(hold), .show_tp(show_tp));

	// --------------------------------------------------
	// frame sequencing and pixel source
	// --------------------------------------------------
	lcd_sequencer lcd_sequencer0 (.clk27(clk27), .rst_n(rst_n), .hold(hold),
		.show_tp(show_tp), .busy(busy), .pixel(pixel), .lcd_rst_n(serlcd_ena),
		.pix_x(pix_x), .pix_y(pix_y), .tp_frame(tp_frame), .tx_byte(tx_byte),
		.tx_is_data(tx_is_data), .tx_strobe(tx_strobe));

	tile_pattern tile_pattern0 (.clk27(clk27), .rst_n(rst_n), .pix_x(pix_x),
		.pix_y(pix_y), .tp_frame(tp_frame), .pixel(pixel));

	// --------------------------------------------------
	// serial output
	// --------------------------------------------------
	serial_shifter serial_shifter0 (.clk27(clk27), .rst_n(rst_n), .tx_byte(tx_byte),
		.tx_is_data(tx_is_data), .tx_strobe(tx_strobe), .busy(busy),
		.lcd_sel_n(serlcd_sel), .lcd_cmd(serlcd_cmd), .lcd_sclk(serlcd_clk),
		.lcd_sdo(serlcd_out));

endmodule

// File: source/serial_shifter.sv
/* strobe only while busy is low; serial clock runs at half of clk27,
   data changes with the clock low, mode 0 */

module serial_shifter (
	input  logic           clk27,
	input  logic           rst_n,
	input  lcd_pkg::byte_t tx_byte,
	input  logic           tx_is_data,
	input  logic           tx_strobe,
	output logic           busy,
	output logic           lcd_sel_n,
	output logic           lcd_cmd,
	output logic           lcd_sclk,
	output logic           lcd_sdo
);

	lcd_pkg::byte_t shreg;
	logic [2:0]     bit_cnt;
	// 0 with clock low, 1 with clock high
	logic           phase;

	// --------------------------------------------------
	// bit timing and select
	// --------------------------------------------------
	always_ff @(posedge clk27 or negedge rst_n) begin
		if (!rst_n) begin
			busy      <= 1'b0;
			phase     <= 1'b0;
			bit_cnt   <= '0;
			lcd_sel_n <= 1'b1;
		end else if (tx_strobe) begin
			busy      <= 1'b1;
			phase     <= 1'b0;
			bit_cnt   <= '0;
			lcd_sel_n <= 1'b0;
		end else if (busy) begin
			phase <= ~phase;
			if (phase) begin
				bit_cnt <= bit_cnt + 1'b1;
				// last bit done
				if (bit_cnt == 3'd7)
					busy <= 1'b0;
			end
		end else begin
			// no byte followed right away
			lcd_sel_n <= 1'b1;
		end
	end

	// byte and flag, msb first
	always_ff @(posedge clk27) begin
		if (tx_strobe) begin
			shreg   <= tx_byte;
			lcd_cmd <= tx_is_data;
		end else if (busy && phase) begin
			shreg <= {shreg[6:0], 1'b0};
		end
	end

	assign lcd_sclk = phase;
	assign lcd_sdo  = shreg[7];

endmodule

// File: source/tile_pattern.sv
/* one pixel of latency; coordinates must stay put for at least
   two cycles before the colour is read */

module tile_pattern (
	input  logic           clk27,
	input  logic           rst_n,
	input  lcd_pkg::hpix_t pix_x,
	input  lcd_pkg::vpix_t pix_y,
	input  logic           tp_frame,
	output lcd_pkg::pixel_t pixel
);

	lcd_pkg::tile_x_t tile_x;
	lcd_pkg::tile_y_t tile_y;
	// wide enough for 14 + 16
	logic [5:0]       tile_sum;
	lcd_pkg::pixel_t  color;

	// --------------------------------------------------
	// tile coordinates
	// --------------------------------------------------
	assign tile_x = lcd_pkg::tile_x_t'(pix_x / lcd_pkg::TILE_WIDTH);
	assign tile_y = lcd_pkg::tile_y_t'(pix_y / lcd_pkg::TILE_HEIGHT);
	assign tile_sum = tile_x + tile_y;

	// checkerboard from the parity of the tile sum
	always_comb begin
		if (!tp_frame)
			color = lcd_pkg::COLOR_SOLID;
		else if (tile_sum[0])
			color = lcd_pkg::COLOR_TILE_ODD;
		else
			color = lcd_pkg::COLOR_TILE_EVEN;
	end

	// --------------------------------------------------
	// output register
	// --------------------------------------------------
	always_ff @(posedge clk27 or negedge rst_n) begin
		if (!rst_n)
			pixel <= '0;
		else
			pixel <= color;
	end

endmodule
